// ==== Makefile ====
SOURCES = $(wildcard rtl/*.sv) $(wildcard testbench/*.sv)

.PHONY: all run clean

all: run

obj_dir/VtbCore: all.f $(SOURCES)
	verilator --binary --assert -j 0 --top-module tbCore -f all.f -Mdir obj_dir

run: obj_dir/VtbCore testbench/coreTests.txt
	./obj_dir/VtbCore | tee sim.log
	grep -qx "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
rtl/mipsPkg.sv
rtl/regFile.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/hazardUnit.sv
rtl/executeStage.sv
rtl/memWbStage.sv
rtl/mipsCore.sv
testbench/tbCore.sv

// ==== rtl/decodeStage.sv ====
/*
 Decode, operand forwarding and branch resolution.
 BEQ, BNE and J redirect fetch from here; unknown opcodes decode as bubbles.
*/
`timescale 1ns/100ps

module decodeStage (
    input  logic clk,
    input  logic rst,
    input  mipsPkg::instrT fetchInstr,
    input  logic [mipsPkg::dataWidth-1:0] fetchPcPlus4,
    input  logic stallFront,
    input  mipsPkg::fwdSelT rsFwdSel,
    input  mipsPkg::fwdSelT rtFwdSel,
    input  logic [mipsPkg::dataWidth-1:0] memResult,
    input  logic wbWrite,
    input  logic [mipsPkg::regAddrWidth-1:0] wbDest,
    input  logic [mipsPkg::dataWidth-1:0] wbData,
    output logic redirect,
    output logic [mipsPkg::dataWidth-1:0] redirectPc,
    output logic [mipsPkg::regAddrWidth-1:0] decodeRs,
    output logic [mipsPkg::regAddrWidth-1:0] decodeRt,
    output logic decodeUsesRt,
    output logic decodeIsBranch,
    output mipsPkg::idExT idEx
);

    mipsPkg::ctrlT ctrl;
    mipsPkg::idExT idExNext;
    logic [mipsPkg::dataWidth-1:0] rfA;
    logic [mipsPkg::dataWidth-1:0] rfB;
    logic [mipsPkg::dataWidth-1:0] opA;
    logic [mipsPkg::dataWidth-1:0] opB;
    logic [mipsPkg::dataWidth-1:0] extImm;
    logic [mipsPkg::dataWidth-1:0] branchTarget;
    logic [mipsPkg::dataWidth-1:0] jumpTarget;
    logic isRType;
    logic isBeq;
    logic isBne;
    logic isJump;
    logic operandsEqual;

    regFile regs (
        .clk(clk),
        .rst(rst),
        .readAddrA(decodeRs),
        .readAddrB(decodeRt),
        .writeAddr(wbDest),
        .writeData(wbData),
        .writeEnable(wbWrite),
        .readDataA(rfA),
        .readDataB(rfB)
    );

    always_comb
    begin
        ctrl = '0;
        case (fetchInstr.rType.op)
            mipsPkg::opRType:
            begin
                ctrl.regWrite = 1'b1;
                case (fetchInstr.rType.funct)
                    mipsPkg::functAddu: ctrl.aluOp = mipsPkg::aluAdd;
                    mipsPkg::functSubu: ctrl.aluOp = mipsPkg::aluSub;
                    mipsPkg::functAnd:  ctrl.aluOp = mipsPkg::aluAnd;
                    mipsPkg::functOr:   ctrl.aluOp = mipsPkg::aluOr;
                    mipsPkg::functSlt:  ctrl.aluOp = mipsPkg::aluSlt;
                    default:            ctrl.regWrite = 1'b0;
                endcase
            end
            mipsPkg::opAddiu:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            mipsPkg::opOri:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.zeroExtImm = 1'b1;
                ctrl.aluOp = mipsPkg::aluOr;
            end
            mipsPkg::opLui:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = mipsPkg::aluLui;
            end
            mipsPkg::opLw:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            mipsPkg::opSw:
            begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            default:
                ctrl = '0;
        endcase
    end

    assign isRType = fetchInstr.rType.op == mipsPkg::opRType;
    assign isBeq = fetchInstr.iType.op == mipsPkg::opBeq;
    assign isBne = fetchInstr.iType.op == mipsPkg::opBne;
    assign isJump = fetchInstr.jType.op == mipsPkg::opJ;
    assign decodeIsBranch = isBeq | isBne;
    assign decodeUsesRt = isRType | decodeIsBranch;
    assign decodeRs = fetchInstr.rType.rs;
    assign decodeRt = fetchInstr.rType.rt;

    assign extImm = ctrl.zeroExtImm ? {16'h0000, fetchInstr.iType.imm}
                                    : {{16{fetchInstr.iType.imm[15]}}, fetchInstr.iType.imm};
    assign opA = mipsPkg::fwdMux(rsFwdSel, rfA, memResult, wbData);
    assign opB = mipsPkg::fwdMux(rtFwdSel, rfB, memResult, wbData);

    // Targets are relative to the delay slot address
    assign operandsEqual = opA == opB;
    assign branchTarget = fetchPcPlus4 + {extImm[29:0], 2'b00};
    assign jumpTarget = {fetchPcPlus4[31:28], fetchInstr.jType.target, 2'b00};
    assign redirect = isJump | (isBeq & operandsEqual) | (isBne & ~operandsEqual);
    assign redirectPc = isJump ? jumpTarget : branchTarget;

    always_comb
    begin
        idExNext.ctrl = ctrl;
        idExNext.rs = decodeRs;
        idExNext.rt = decodeRt;
        idExNext.dest = isRType ? fetchInstr.rType.rd : fetchInstr.iType.rt;
        idExNext.opA = opA;
        idExNext.opB = opB;
        idExNext.imm = extImm;
        idExNext.valid = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst || stallFront)
        begin
            idEx.ctrl <= '0;
            idEx.valid <= 1'b0;
        end
        else
            idEx <= idExNext;
    end

endmodule

// ==== rtl/executeStage.sv ====
/*
 Execute stage with operand forwarding and the ALU.
 SLT compares signed; LUI places the low immediate half in the upper half.
*/
`timescale 1ns/100ps

module executeStage (
    input  logic clk,
    input  logic rst,
    input  mipsPkg::idExT idEx,
    input  mipsPkg::fwdSelT exRsFwdSel,
    input  mipsPkg::fwdSelT exRtFwdSel,
    input  logic [mipsPkg::dataWidth-1:0] memResult,
    input  logic [mipsPkg::dataWidth-1:0] wbData,
    output mipsPkg::exMemT exMem
);

    logic [mipsPkg::dataWidth-1:0] opA;
    logic [mipsPkg::dataWidth-1:0] rtValue;
    logic [mipsPkg::dataWidth-1:0] opB;
    logic [mipsPkg::dataWidth-1:0] result;

    assign opA = mipsPkg::fwdMux(exRsFwdSel, idEx.opA, memResult, wbData);
    assign rtValue = mipsPkg::fwdMux(exRtFwdSel, idEx.opB, memResult, wbData);
    assign opB = idEx.ctrl.aluSrcImm ? idEx.imm : rtValue;

    always_comb
    begin
        case (idEx.ctrl.aluOp)
            mipsPkg::aluAdd: result = opA + opB;
            mipsPkg::aluSub: result = opA - opB;
            mipsPkg::aluAnd: result = opA & opB;
            mipsPkg::aluOr:  result = opA | opB;
            mipsPkg::aluSlt: result = {{(mipsPkg::dataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
            mipsPkg::aluLui: result = {opB[15:0], 16'h0000};
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            exMem.regWrite <= 1'b0;
            exMem.memRead <= 1'b0;
            exMem.memWrite <= 1'b0;
            exMem.memToReg <= 1'b0;
        end
        else
        begin
            exMem.regWrite <= idEx.valid & idEx.ctrl.regWrite;
            exMem.memRead <= idEx.valid & idEx.ctrl.memRead;
            exMem.memWrite <= idEx.valid & idEx.ctrl.memWrite;
            exMem.memToReg <= idEx.ctrl.memToReg;
            exMem.dest <= idEx.dest;
            exMem.aluResult <= result;
            // Store data may still be replaced in the memory stage
            exMem.storeData <= rtValue;
        end
    end

endmodule

// ==== rtl/fetchStage.sv ====
/*
 PC and fetch/decode register. Fetch starts one cycle after reset is released,
 and a redirect from decode loads the PC while the delay slot moves on.
*/
`timescale 1ns/100ps

module fetchStage (
    input  logic clk,
    input  logic rst,
    input  logic stallFront,
    input  logic redirect,
    input  logic [mipsPkg::dataWidth-1:0] redirectPc,
    input  logic [mipsPkg::dataWidth-1:0] instMemIn,
    output logic [mipsPkg::addrWidth-1:0] instMemAddress,
    output logic instMemRead,
    output mipsPkg::instrT fetchInstr,
    output logic [mipsPkg::dataWidth-1:0] fetchPcPlus4
);

    logic [mipsPkg::dataWidth-1:0] pc;
    logic [mipsPkg::dataWidth-1:0] pcPlus4;
    logic running;
    logic advance;

    assign pcPlus4 = pc + 32'd4;
    assign advance = running & ~stallFront;
    assign instMemAddress = pc[mipsPkg::dataWidth-1:2];
    assign instMemRead = advance;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            running <= 1'b0;
            pc <= '0;
            // Zero word decodes with no control bits set
            fetchInstr <= '0;
        end
        else
        begin
            running <= 1'b1;
            if (advance)
            begin
                pc <= redirect ? redirectPc : pcPlus4;
                fetchInstr <= instMemIn;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (advance)
            fetchPcPlus4 <= pcPlus4;
    end

endmodule

// ==== rtl/hazardUnit.sv ====
/*
 Stall and forwarding-select logic for the whole pipeline.
 Loads forward only from writeback, so their users stall as needed.
*/
`timescale 1ns/100ps

module hazardUnit (
    input  logic [mipsPkg::regAddrWidth-1:0] decodeRs,
    input  logic [mipsPkg::regAddrWidth-1:0] decodeRt,
    input  logic decodeUsesRt,
    input  logic decodeIsBranch,
    input  mipsPkg::idExT idEx,
    input  mipsPkg::exMemT exMem,
    input  mipsPkg::memWbT memWb,
    output logic stallFront,
    output mipsPkg::fwdSelT idRsFwdSel,
    output mipsPkg::fwdSelT idRtFwdSel,
    output mipsPkg::fwdSelT exRsFwdSel,
    output mipsPkg::fwdSelT exRtFwdSel,
    output logic storeFwd
);

    logic rsHitEx;
    logic rtHitEx;
    logic loadUse;
    logic branchWait;

    function automatic logic writes(
        input logic enable,
        input logic [mipsPkg::regAddrWidth-1:0] dest,
        input logic [mipsPkg::regAddrWidth-1:0] src
    );
        writes = enable && dest != '0 && dest == src;
    endfunction

    // Memory stage is younger than writeback, so it wins
    function automatic mipsPkg::fwdSelT pickSource(
        input logic [mipsPkg::regAddrWidth-1:0] src,
        input mipsPkg::exMemT mem,
        input mipsPkg::memWbT wb
    );
        if (writes(mem.regWrite, mem.dest, src))
            pickSource = mipsPkg::fwdFromMem;
        else if (writes(wb.regWrite, wb.dest, src))
            pickSource = mipsPkg::fwdFromWb;
        else
            pickSource = mipsPkg::fwdNone;
    endfunction

    assign idRsFwdSel = pickSource(decodeRs, exMem, memWb);
    assign idRtFwdSel = pickSource(decodeRt, exMem, memWb);
    assign exRsFwdSel = pickSource(idEx.rs, exMem, memWb);
    assign exRtFwdSel = pickSource(idEx.rt, exMem, memWb);

    assign rsHitEx = writes(idEx.ctrl.regWrite, idEx.dest, decodeRs);
    assign rtHitEx = writes(idEx.ctrl.regWrite, idEx.dest, decodeRt);
    assign loadUse = idEx.ctrl.memRead & (rsHitEx | (decodeUsesRt & rtHitEx));

    // Branch compares in decode, so a result still in execute or a load in memory must wait
    assign branchWait = decodeIsBranch & (rsHitEx | rtHitEx
                      | writes(exMem.memRead, exMem.dest, decodeRs)
                      | writes(exMem.memRead, exMem.dest, decodeRt));
    assign stallFront = loadUse | branchWait;

    assign storeFwd = exMem.memWrite & writes(memWb.regWrite, memWb.dest, exMem.dest);

endmodule

// ==== rtl/memWbStage.sv ====
/*
 Data port drive, memory/writeback register and writeback select.
 The data memory is zero-wait, so load data is captured in the same cycle.
*/
`timescale 1ns/100ps

module memWbStage (
    input  logic clk,
    input  logic rst,
    input  mipsPkg::exMemT exMem,
    input  logic storeFwd,
    input  logic [mipsPkg::dataWidth-1:0] dataMemIn,
    output logic dataMemRead,
    output logic [3:0] dataMemWrite,
    output logic [mipsPkg::addrWidth-1:0] dataMemAddress,
    output logic [mipsPkg::dataWidth-1:0] dataMemOut,
    output logic [mipsPkg::dataWidth-1:0] memResult,
    output mipsPkg::memWbT memWb,
    output logic wbWrite,
    output logic [mipsPkg::regAddrWidth-1:0] wbDest,
    output logic [mipsPkg::dataWidth-1:0] wbData
);

    assign dataMemRead = exMem.memRead;
    // Word stores only, all byte lanes together
    assign dataMemWrite = {4{exMem.memWrite}};
    assign dataMemAddress = exMem.aluResult[mipsPkg::dataWidth-1:2];
    assign dataMemOut = storeFwd ? wbData : exMem.storeData;
    assign memResult = exMem.aluResult;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            memWb.regWrite <= 1'b0;
            memWb.memToReg <= 1'b0;
        end
        else
        begin
            memWb.regWrite <= exMem.regWrite;
            memWb.memToReg <= exMem.memToReg;
            memWb.dest <= exMem.dest;
            memWb.aluResult <= exMem.aluResult;
            memWb.loadData <= dataMemIn;
        end
    end

    assign wbWrite = memWb.regWrite;
    assign wbDest = memWb.dest;
    assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluResult;

endmodule

// ==== rtl/mipsCore.sv ====
/*
 Five-stage MIPS integer core with separate zero-wait instruction and data ports.
 Addresses on both ports are word addresses. Branch delay slots always execute.
*/
`timescale 1ns/100ps

module mipsCore (
    input  logic clk,
    input  logic rst,
    input  logic [mipsPkg::dataWidth-1:0] instMemIn,
    output logic [mipsPkg::addrWidth-1:0] instMemAddress,
    output logic instMemRead,
    input  logic [mipsPkg::dataWidth-1:0] dataMemIn,
    output logic dataMemRead,
    output logic [3:0] dataMemWrite,
    output logic [mipsPkg::addrWidth-1:0] dataMemAddress,
    output logic [mipsPkg::dataWidth-1:0] dataMemOut
);

    mipsPkg::instrT fetchInstr;
    logic [mipsPkg::dataWidth-1:0] fetchPcPlus4;
    logic redirect;
    logic [mipsPkg::dataWidth-1:0] redirectPc;
    logic stallFront;

    logic [mipsPkg::regAddrWidth-1:0] decodeRs;
    logic [mipsPkg::regAddrWidth-1:0] decodeRt;
    logic decodeUsesRt;
    logic decodeIsBranch;

    mipsPkg::idExT idEx;
    mipsPkg::exMemT exMem;
    mipsPkg::memWbT memWb;

    mipsPkg::fwdSelT idRsFwdSel;
    mipsPkg::fwdSelT idRtFwdSel;
    mipsPkg::fwdSelT exRsFwdSel;
    mipsPkg::fwdSelT exRtFwdSel;
    logic storeFwd;

    logic [mipsPkg::dataWidth-1:0] memResult;
    logic wbWrite;
    logic [mipsPkg::regAddrWidth-1:0] wbDest;
    logic [mipsPkg::dataWidth-1:0] wbData;

    fetchStage fetch (
        .clk(clk),
        .rst(rst),
        .stallFront(stallFront),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .instMemIn(instMemIn),
        .instMemAddress(instMemAddress),
        .instMemRead(instMemRead),
        .fetchInstr(fetchInstr),
        .fetchPcPlus4(fetchPcPlus4)
    );

    decodeStage decode (
        .clk(clk),
        .rst(rst),
        .fetchInstr(fetchInstr),
        .fetchPcPlus4(fetchPcPlus4),
        .stallFront(stallFront),
        .rsFwdSel(idRsFwdSel),
        .rtFwdSel(idRtFwdSel),
        .memResult(memResult),
        .wbWrite(wbWrite),
        .wbDest(wbDest),
        .wbData(wbData),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .decodeRs(decodeRs),
        .decodeRt(decodeRt),
        .decodeUsesRt(decodeUsesRt),
        .decodeIsBranch(decodeIsBranch),
        .idEx(idEx)
    );

    hazardUnit hazard (
        .decodeRs(decodeRs),
        .decodeRt(decodeRt),
        .decodeUsesRt(decodeUsesRt),
        .decodeIsBranch(decodeIsBranch),
        .idEx(idEx),
        .exMem(exMem),
        .memWb(memWb),
        .stallFront(stallFront),
        .idRsFwdSel(idRsFwdSel),
        .idRtFwdSel(idRtFwdSel),
        .exRsFwdSel(exRsFwdSel),
        .exRtFwdSel(exRtFwdSel),
        .storeFwd(storeFwd)
    );

    executeStage execute (
        .clk(clk),
        .rst(rst),
        .idEx(idEx),
        .exRsFwdSel(exRsFwdSel),
        .exRtFwdSel(exRtFwdSel),
        .memResult(memResult),
        .wbData(wbData),
        .exMem(exMem)
    );

    memWbStage memWbSt (
        .clk(clk),
        .rst(rst),
        .exMem(exMem),
        .storeFwd(storeFwd),
        .dataMemIn(dataMemIn),
        .dataMemRead(dataMemRead),
        .dataMemWrite(dataMemWrite),
        .dataMemAddress(dataMemAddress),
        .dataMemOut(dataMemOut),
        .memResult(memResult),
        .memWb(memWb),
        .wbWrite(wbWrite),
        .wbDest(wbDest),
        .wbData(wbData)
    );

endmodule

// ==== rtl/mipsPkg.sv ====
/*
 Shared widths, opcodes and pipeline types of the MIPS core.
 Only the integer subset below is decoded. Any other word behaves as a bubble.
*/
package mipsPkg;

    localparam int dataWidth = 32;
    localparam int addrWidth = 30;
    localparam int regAddrWidth = 5;

    // Primary opcodes
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    // R-type function codes
    localparam logic [5:0] functAddu = 6'h21;
    localparam logic [5:0] functSubu = 6'h23;
    localparam logic [5:0] functAnd  = 6'h24;
    localparam logic [5:0] functOr   = 6'h25;
    localparam logic [5:0] functSlt  = 6'h2a;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui} aluOpT;

    typedef enum logic [1:0] {fwdNone, fwdFromMem, fwdFromWb} fwdSelT;

    typedef struct packed {
        logic [5:0] op;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0] op;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [15:0] imm;
    } iTypeT;

    typedef struct packed {
        logic [5:0] op;
        logic [25:0] target;
    } jTypeT;

    // One fetched word seen in each of the three formats
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        jTypeT jType;
    } instrT;

    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic aluSrcImm;
        logic zeroExtImm;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        ctrlT ctrl;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] dest;
        logic [dataWidth-1:0] opA;
        logic [dataWidth-1:0] opB;
        logic [dataWidth-1:0] imm;
        logic valid;
    } idExT;

    // For a store, dest carries rt so the store data can be forwarded
    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic [regAddrWidth-1:0] dest;
        logic [dataWidth-1:0] aluResult;
        logic [dataWidth-1:0] storeData;
    } exMemT;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
        logic [regAddrWidth-1:0] dest;
        logic [dataWidth-1:0] aluResult;
        logic [dataWidth-1:0] loadData;
    } memWbT;

    // Operand mux shared by the decode and execute forwarding paths
    function automatic logic [dataWidth-1:0] fwdMux(
        input fwdSelT sel,
        input logic [dataWidth-1:0] regVal,
        input logic [dataWidth-1:0] memVal,
        input logic [dataWidth-1:0] wbVal
    );
        case (sel)
            fwdFromMem: fwdMux = memVal;
            fwdFromWb:  fwdMux = wbVal;
            default:    fwdMux = regVal;
        endcase
    endfunction

endpackage

// ==== rtl/regFile.sv ====
/*
 32x32 register file, register 0 reads as zero.
 A write is visible to a read of the same register in the same cycle.
*/
`timescale 1ns/100ps

module regFile (
    input  logic clk,
    input  logic rst,
    input  logic [mipsPkg::regAddrWidth-1:0] readAddrA,
    input  logic [mipsPkg::regAddrWidth-1:0] readAddrB,
    input  logic [mipsPkg::regAddrWidth-1:0] writeAddr,
    input  logic [mipsPkg::dataWidth-1:0] writeData,
    input  logic writeEnable,
    output logic [mipsPkg::dataWidth-1:0] readDataA,
    output logic [mipsPkg::dataWidth-1:0] readDataB
);

    logic [mipsPkg::dataWidth-1:0] regs [1:31];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (writeEnable && writeAddr != '0)
            regs[writeAddr] <= writeData;
    end

    // Write-through models the first-half-cycle write
    assign readDataA = (readAddrA == '0) ? '0
                     : (writeEnable && writeAddr == readAddrA) ? writeData : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0
                     : (writeEnable && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

// ==== testbench/coreTests.txt ====
// Columns: tag, word address (hex), data word (hex); the rest of a line is a comment
// Tags: I program word, D initial data word, S expected store in the order it must occur
I 00 3C011234 // lui   $1, 0x1234
I 01 34215678 // ori   $1, $1, 0x5678
I 02 AC010100 // sw    $1, 0x100($0)
I 03 2402FFF0 // addiu $2, $0, -16
I 04 24030007 // addiu $3, $0, 7
I 05 00432021 // addu  $4, $2, $3
I 06 00622823 // subu  $5, $3, $2
I 07 00223024 // and   $6, $1, $2
I 08 00233825 // or    $7, $1, $3
I 09 0043402A // slt   $8, $2, $3
I 0A 0062482A // slt   $9, $3, $2
I 0B AC040104 // sw    $4, 0x104($0)
I 0C AC050108 // sw    $5, 0x108($0)
I 0D AC06010C // sw    $6, 0x10c($0)
I 0E AC070110 // sw    $7, 0x110($0)
I 0F AC080114 // sw    $8, 0x114($0)
I 10 AC090118 // sw    $9, 0x118($0)
I 11 8C0A0200 // lw    $10, 0x200($0)
I 12 014A5821 // addu  $11, $10, $10 (load-use)
I 13 AC0B011C // sw    $11, 0x11c($0)
I 14 8C0C0204 // lw    $12, 0x204($0)
I 15 118B0003 // beq   $12, $11, +3 (taken, operand from load)
I 16 240D0055 // addiu $13, $0, 0x55 (delay slot)
I 17 AC0D01F0 // sw    $13, 0x1f0($0) skipped
I 18 AC0D01F4 // sw    $13, 0x1f4($0) skipped
I 19 AC0D0120 // sw    $13, 0x120($0)
I 1A 156C0006 // bne   $11, $12, +6 (not taken)
I 1B 25AD0001 // addiu $13, $13, 1 (delay slot)
I 1C AC0D0124 // sw    $13, 0x124($0)
I 1D 11AB0003 // beq   $13, $11, +3 (not taken)
I 1E 240E0003 // addiu $14, $0, 3 (delay slot)
I 1F 15C00003 // bne   $14, $0, +3 (taken, operand in execute)
I 20 25CE0001 // addiu $14, $14, 1 (delay slot)
I 21 AC0E01F8 // sw    $14, 0x1f8($0) skipped
I 22 AC0E01FC // sw    $14, 0x1fc($0) skipped
I 23 AC0E0128 // sw    $14, 0x128($0)
I 24 08000028 // j     0x28
I 25 240F0077 // addiu $15, $0, 0x77 (delay slot)
I 26 AC0F01E0 // sw    $15, 0x1e0($0) skipped
I 27 AC0F01E4 // sw    $15, 0x1e4($0) skipped
I 28 AC0F012C // sw    $15, 0x12c($0)
I 29 25EF0001 // addiu $15, $15, 1
I 2A AC0F0130 // sw    $15, 0x130($0)
I 2B 8C100208 // lw    $16, 0x208($0)
I 2C AC100134 // sw    $16, 0x134($0) (store data from load)
I 2D 0800002D // j     0x2d (park here)
I 2E 00000000 // nop (delay slot)
D 80 00000005
D 81 0000000A
D 82 CAFEF00D
S 40 12345678
S 41 FFFFFFF7
S 42 00000017
S 43 12345670
S 44 1234567F
S 45 00000001
S 46 00000000
S 47 0000000A
S 48 00000055
S 49 00000056
S 4A 00000004
S 4B 00000077
S 4C 00000078
S 4D CAFEF00D

// ==== testbench/tbCore.sv ====
/*
 Testbench for mipsCore. Run from the project root, it reads testbench/coreTests.txt.
 Both memory models hold 256 words; stores must match the S lines in order.
*/
`timescale 1ns/100ps

module tbCore;

    typedef struct packed {
        logic [mipsPkg::addrWidth-1:0] addr;
        logic [mipsPkg::dataWidth-1:0] data;
    } storeT;

    logic clk;
    logic rst;
    logic [mipsPkg::dataWidth-1:0] instMemIn;
    logic [mipsPkg::addrWidth-1:0] instMemAddress;
    logic instMemRead;
    logic [mipsPkg::dataWidth-1:0] dataMemIn;
    logic dataMemRead;
    logic [3:0] dataMemWrite;
    logic [mipsPkg::addrWidth-1:0] dataMemAddress;
    logic [mipsPkg::dataWidth-1:0] dataMemOut;

    logic [mipsPkg::dataWidth-1:0] instMem [0:255];
    logic [mipsPkg::dataWidth-1:0] dataMem [0:255];
    storeT expected[$];
    int programWords;
    int cycles;
    int cyclesOutOfReset;
    int quietCycles;
    logic loadOk;

    mipsCore DUT (
        .clk(clk),
        .rst(rst),
        .instMemIn(instMemIn),
        .instMemAddress(instMemAddress),
        .instMemRead(instMemRead),
        .dataMemIn(dataMemIn),
        .dataMemRead(dataMemRead),
        .dataMemWrite(dataMemWrite),
        .dataMemAddress(dataMemAddress),
        .dataMemOut(dataMemOut)
    );

    always #2 clk = ~clk;

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic skipLine(input int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1)
            ch = $fgetc(fd);
    endtask

    task automatic loadTests(output logic ok);
        int fd;
        int count;
        logic [7:0] tag;
        logic [mipsPkg::addrWidth-1:0] addr;
        logic [mipsPkg::dataWidth-1:0] word;
        storeT entry;
        ok = 1'b1;
        // Unlisted program words are NOPs, unlisted data words carry their own index
        for (int i = 0; i < 256; i++)
        begin
            instMem[i] = '0;
            dataMem[i] = 32'hdead0000 | i;
        end
        fd = $fopen("testbench/coreTests.txt", "r");
        if (fd == 0)
            ok = 1'b0;
        else
        begin
            while (!$feof(fd))
            begin
                count = $fscanf(fd, " %c", tag);
                if (count == 1 && tag != "/")
                begin
                    count = $fscanf(fd, "%h %h", addr, word);
                    if (count != 2 || addr[mipsPkg::addrWidth-1:8] != '0)
                        ok = 1'b0;
                    else if (tag == "I")
                    begin
                        instMem[addr[7:0]] = word;
                        programWords++;
                    end
                    else if (tag == "D")
                        dataMem[addr[7:0]] = word;
                    else if (tag == "S")
                    begin
                        entry.addr = addr;
                        entry.data = word;
                        expected.push_back(entry);
                    end
                    else
                        ok = 1'b0;
                end
                // Trailing text on a line is a comment
                skipLine(fd);
            end
            $fclose(fd);
        end
        if (programWords == 0 || expected.size() == 0)
            ok = 1'b0;
    endtask

    task automatic checkStore;
        storeT want;
        if (expected.size() == 0)
            stopOnError($sformatf("an unexpected extra store to word %h came at %0t",
                                  dataMemAddress, $time));
        else
        begin
            want = expected.pop_front();
            assert (dataMemWrite == 4'b1111)
            else stopOnError($sformatf("mismatch at %0t: byte strobes %b, expected 1111",
                                       $time, dataMemWrite));
            assert (dataMemAddress == want.addr && dataMemOut == want.data)
            else stopOnError($sformatf(
                "mismatch at %0t: store of %h to word %h, expected %h to word %h",
                $time, dataMemOut, dataMemAddress, want.data, want.addr));
        end
    endtask

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        instMemIn = '0;
        dataMemIn = '0;
        programWords = 0;
        cycles = 0;
        cyclesOutOfReset = 0;
        quietCycles = 0;
        loadTests(loadOk);
        if (!loadOk)
            stopOnError("testbench/coreTests.txt is missing or holds a malformed line");
        else
        begin
            repeat (2) @(posedge clk);
            #1;
            rst = 1'b0;
        end
    end

    // Each memory answers shortly after the edge while its read strobe is high
    always @(posedge clk)
    begin
        cycles++;
        #1;
        if (instMemRead && instMemAddress[mipsPkg::addrWidth-1:8] == '0)
            instMemIn = instMem[instMemAddress[7:0]];
        else
            instMemIn = '0;
        if (dataMemRead && dataMemAddress[mipsPkg::addrWidth-1:8] == '0)
            dataMemIn = dataMem[dataMemAddress[7:0]];
        else
            dataMemIn = '0;
    end

    // Mid-cycle, where all DUT outputs are settled
    always @(negedge clk)
    begin
        if (cycles > 0)
        begin
            if (rst || cyclesOutOfReset == 0)
            begin
                assert (!instMemRead && !dataMemRead && dataMemWrite == 4'b0000)
                else stopOnError("a memory strobe was active during reset or the cycle after it");
            end
            if (!rst)
                cyclesOutOfReset++;
            if (dataMemWrite != 4'b0000)
            begin
                quietCycles = 0;
                checkStore();
                if (dataMemAddress[mipsPkg::addrWidth-1:8] == '0)
                    dataMem[dataMemAddress[7:0]] = dataMemOut;
            end
            else
                quietCycles++;
            // Thirty cycles per program word covers every stall with a wide margin
            if (cycles > 30 * programWords)
                stopOnError($sformatf("timeout after %0d cycles with %0d stores still missing",
                                      cycles, expected.size()));
            else if (expected.size() == 0 && quietCycles >= 20)
            begin
                $display("all tests passed");
                $finish;
            end
        end
    end

endmodule
